//--- common/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// datapath and pc width
`define EXEC_XLEN       32

// size of one instruction in bytes
`define EXEC_PC_STEP    4

`define EXEC_TAG_W      6

// trap codes
`define EXEC_TRAP_W     4
`define EXEC_TRAP_MRET  4'd3

`endif

//--- common/exec_pkg.sv
`include "exec_macros.svh"

package exec_pkg;

    // ----------------------------------------
    // operation encodings
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        OPND_ZERO = 3'd0,
        OPND_RS1  = 3'd1,
        OPND_RS2  = 3'd2,
        OPND_IMM  = 3'd3,
        OPND_CSR  = 3'd4,
        OPND_PC   = 3'd5
    } opnd_sel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_BLT  = 3'd3,
        BR_BGE  = 3'd4,
        BR_JAL  = 3'd5,
        BR_JALR = 3'd6
    } br_op_e;

    typedef enum logic [1:0] {
        WB_ALU   = 2'd0,
        WB_OPND1 = 2'd1,
        WB_LINK  = 2'd2,  // pc + 4
        WB_CSR   = 2'd3
    } wb_sel_e;

    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_MRET = 2'd3
    } csr_op_e;

    // ----------------------------------------
    // stage records
    // ----------------------------------------
    typedef struct packed {
        logic [`EXEC_TAG_W-1:0] tag;
        logic [`EXEC_XLEN-1:0]  pc;
        logic [`EXEC_XLEN-1:0]  rs1;
        logic [`EXEC_XLEN-1:0]  rs2;
        logic [`EXEC_XLEN-1:0]  imm;
        logic [`EXEC_XLEN-1:0]  csr;   // csr value read in decode
        alu_op_e                alu_op;
        opnd_sel_e              opnd1_sel;
        opnd_sel_e              opnd2_sel;
        br_op_e                 br_op;
        wb_sel_e                wb_sel;
        csr_op_e                csr_op;
        logic                   pred_taken;
    } uop_t;

    typedef struct packed {
        logic [`EXEC_TAG_W-1:0]  tag;
        logic [`EXEC_XLEN-1:0]   rd_data;
        logic [`EXEC_XLEN-1:0]   csr_wdata;
        logic                    br_update;   // predictor update
        logic                    br_taken;
        logic                    mispredict;
        logic                    redirect;
        logic [`EXEC_XLEN-1:0]   redirect_pc;
        logic                    trap;
        logic [`EXEC_TRAP_W-1:0] trap_code;
    } exec_result_t;

endpackage

//--- rtl/hs_slot.sv
`timescale 1ns/1ps

// one-entry register slot between two four-phase links
module hs_slot #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rstn_i,

    // upstream, this side receives
    input  logic up_req_i,
    output logic up_ack_o,
    input  T     up_data_i,

    // downstream, this side sends
    output logic dn_req_o,
    input  logic dn_ack_i,
    output T     dn_data_o
);

    T     data_q;
    logic full_q;
    logic take;
    logic give;

    // accept only into an empty slot and only on a fresh request
    assign take = up_req_i && !up_ack_o && !full_q;
    assign give = dn_req_o && dn_ack_i;  // receiver has the data

    // ----------------------------------------
    // handshake control
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            full_q   <= 1'b0;
            up_ack_o <= 1'b0;
            dn_req_o <= 1'b0;
        end else begin
            // receive phase
            if (take) begin
                up_ack_o <= 1'b1;
            end else if (up_ack_o && !up_req_i) begin
                up_ack_o <= 1'b0;
            end

            // send phase, wait for the previous ack to drop
            if (give) begin
                dn_req_o <= 1'b0;
            end else if (full_q && !dn_req_o && !dn_ack_i) begin
                dn_req_o <= 1'b1;
            end

            if (take) begin
                full_q <= 1'b1;
            end else if (give) begin
                full_q <= 1'b0;  // released together with req falling
            end
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (take) begin
            data_q <= up_data_i;
        end
    end

    assign dn_data_o = data_q;

endmodule

//--- execute/exec_alu.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module exec_alu (
    input  exec_pkg::alu_op_e      alu_op_i,
    input  logic [`EXEC_XLEN-1:0]  opnd1_i,
    input  logic [`EXEC_XLEN-1:0]  opnd2_i,
    output logic [`EXEC_XLEN-1:0]  result_o,
    output logic                   eq_o,
    output logic                   lt_o
);

    logic [4:0] shamt;
    logic       ltu;

    assign shamt = opnd2_i[4:0];
    assign eq_o  = (opnd1_i == opnd2_i);
    assign lt_o  = ($signed(opnd1_i) < $signed(opnd2_i));
    assign ltu   = (opnd1_i < opnd2_i);

    always_comb begin
        result_o = '0;
        case (alu_op_i)
            exec_pkg::ALU_ADD:  result_o = opnd1_i + opnd2_i;
            exec_pkg::ALU_SUB:  result_o = opnd1_i - opnd2_i;
            exec_pkg::ALU_AND:  result_o = opnd1_i & opnd2_i;
            exec_pkg::ALU_OR:   result_o = opnd1_i | opnd2_i;
            exec_pkg::ALU_XOR:  result_o = opnd1_i ^ opnd2_i;
            exec_pkg::ALU_SLL:  result_o = opnd1_i << shamt;
            exec_pkg::ALU_SRL:  result_o = opnd1_i >> shamt;
            exec_pkg::ALU_SRA: begin
                result_o = $unsigned($signed(opnd1_i) >>> shamt);  // sign fill
            end
            exec_pkg::ALU_SLT: begin
                result_o = {{(`EXEC_XLEN-1){1'b0}}, lt_o};
            end
            exec_pkg::ALU_SLTU: begin
                result_o = {{(`EXEC_XLEN-1){1'b0}}, ltu};
            end
            default:            result_o = '0;
        endcase
    end

endmodule

//--- execute/exec_unit.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

// turns one micro-op into a result record, purely combinational
module exec_unit (
    input  exec_pkg::uop_t         uop_i,
    output exec_pkg::exec_result_t result_o
);

    logic [`EXEC_XLEN-1:0] opnd1;
    logic [`EXEC_XLEN-1:0] opnd2;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  alu_eq;
    logic                  alu_lt;
    logic [`EXEC_XLEN-1:0] link_pc;
    logic [`EXEC_XLEN-1:0] jalr_sum;
    logic [`EXEC_XLEN-1:0] br_target;
    logic                  is_cond_br;
    logic                  is_br;
    logic                  taken;

    function automatic logic [`EXEC_XLEN-1:0] sel_opnd(
        input exec_pkg::opnd_sel_e sel,
        input exec_pkg::uop_t      uop
    );
        logic [`EXEC_XLEN-1:0] val;
        case (sel)
            exec_pkg::OPND_RS1: val = uop.rs1;
            exec_pkg::OPND_RS2: val = uop.rs2;
            exec_pkg::OPND_IMM: val = uop.imm;
            exec_pkg::OPND_CSR: val = uop.csr;
            exec_pkg::OPND_PC:  val = uop.pc;
            default:            val = '0;  // zero
        endcase
        return val;
    endfunction

    // ----------------------------------------
    // operands and alu
    // ----------------------------------------
    assign is_cond_br = (uop_i.br_op == exec_pkg::BR_BEQ) ||
                        (uop_i.br_op == exec_pkg::BR_BNE) ||
                        (uop_i.br_op == exec_pkg::BR_BLT) ||
                        (uop_i.br_op == exec_pkg::BR_BGE);
    assign is_br = (uop_i.br_op != exec_pkg::BR_NONE);

    // conditional branches always compare rs1 against rs2
    assign opnd1 = is_cond_br ? uop_i.rs1 : sel_opnd(uop_i.opnd1_sel, uop_i);
    assign opnd2 = is_cond_br ? uop_i.rs2 : sel_opnd(uop_i.opnd2_sel, uop_i);

    exec_alu u_alu (
        .alu_op_i ( uop_i.alu_op ),
        .opnd1_i  ( opnd1        ),
        .opnd2_i  ( opnd2        ),
        .result_o ( alu_result   ),
        .eq_o     ( alu_eq       ),
        .lt_o     ( alu_lt       )
    );

    // ----------------------------------------
    // branch resolution
    // ----------------------------------------
    assign link_pc  = uop_i.pc + `EXEC_PC_STEP;
    assign jalr_sum = uop_i.rs1 + uop_i.imm;

    always_comb begin
        taken = 1'b0;
        case (uop_i.br_op)
            exec_pkg::BR_BEQ:  taken = alu_eq;
            exec_pkg::BR_BNE:  taken = !alu_eq;
            exec_pkg::BR_BLT:  taken = alu_lt;
            exec_pkg::BR_BGE:  taken = !alu_lt;
            exec_pkg::BR_JAL,
            exec_pkg::BR_JALR: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    always_comb begin
        if (uop_i.br_op == exec_pkg::BR_JALR) begin
            br_target = {jalr_sum[`EXEC_XLEN-1:1], 1'b0};  // bit 0 cleared
        end else begin
            br_target = uop_i.pc + uop_i.imm;
        end
    end

    // ----------------------------------------
    // result record
    // ----------------------------------------
    always_comb begin
        result_o     = '0;
        result_o.tag = uop_i.tag;

        case (uop_i.wb_sel)
            exec_pkg::WB_ALU:   result_o.rd_data = alu_result;
            exec_pkg::WB_OPND1: result_o.rd_data = opnd1;
            exec_pkg::WB_LINK:  result_o.rd_data = link_pc;
            exec_pkg::WB_CSR:   result_o.rd_data = uop_i.csr;
            default:            result_o.rd_data = alu_result;
        endcase

        case (uop_i.csr_op)
            exec_pkg::CSR_RW: result_o.csr_wdata = uop_i.rs1;
            exec_pkg::CSR_RS: result_o.csr_wdata = alu_result;  // alu does the or
            exec_pkg::CSR_MRET: begin
                result_o.trap      = 1'b1;
                result_o.trap_code = `EXEC_TRAP_MRET;
            end
            default:          result_o.csr_wdata = '0;
        endcase

        // branch fields stay zero for non-branch ops
        if (is_br) begin
            result_o.br_update   = 1'b1;
            result_o.br_taken    = taken;
            result_o.mispredict  = (taken != uop_i.pred_taken);
            result_o.redirect    = (taken != uop_i.pred_taken);
            result_o.redirect_pc = taken ? br_target : link_pc;
        end
    end

endmodule

//--- rtl/exec_top.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module exec_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    // micro-op in
    input  logic                    uop_req_i,
    output logic                    uop_ack_o,
    input  logic [`EXEC_TAG_W-1:0]  uop_tag_i,
    input  logic [`EXEC_XLEN-1:0]   uop_pc_i,
    input  logic [`EXEC_XLEN-1:0]   uop_rs1_i,
    input  logic [`EXEC_XLEN-1:0]   uop_rs2_i,
    input  logic [`EXEC_XLEN-1:0]   uop_imm_i,
    input  logic [`EXEC_XLEN-1:0]   uop_csr_i,
    input  exec_pkg::alu_op_e       uop_alu_op_i,
    input  exec_pkg::opnd_sel_e     uop_opnd1_sel_i,
    input  exec_pkg::opnd_sel_e     uop_opnd2_sel_i,
    input  exec_pkg::br_op_e        uop_br_op_i,
    input  exec_pkg::wb_sel_e       uop_wb_sel_i,
    input  exec_pkg::csr_op_e       uop_csr_op_i,
    input  logic                    uop_pred_taken_i,

    // result out, toward memory stage
    output logic                    res_req_o,
    input  logic                    res_ack_i,
    output logic [`EXEC_TAG_W-1:0]  res_tag_o,
    output logic [`EXEC_XLEN-1:0]   res_rd_data_o,
    output logic [`EXEC_XLEN-1:0]   res_csr_wdata_o,
    output logic                    res_br_update_o,
    output logic                    res_br_taken_o,
    output logic                    res_mispredict_o,
    output logic                    res_redirect_o,
    output logic [`EXEC_XLEN-1:0]   res_redirect_pc_o,
    output logic                    res_trap_o,
    output logic [`EXEC_TRAP_W-1:0] res_trap_code_o
);

    exec_pkg::uop_t         uop_in;
    exec_pkg::uop_t         uop_q;
    exec_pkg::exec_result_t res_d;
    exec_pkg::exec_result_t res_q;
    logic                   mid_req;   // input slot -> output slot
    logic                   mid_ack;

    assign uop_in = '{
        tag:        uop_tag_i,
        pc:         uop_pc_i,
        rs1:        uop_rs1_i,
        rs2:        uop_rs2_i,
        imm:        uop_imm_i,
        csr:        uop_csr_i,
        alu_op:     uop_alu_op_i,
        opnd1_sel:  uop_opnd1_sel_i,
        opnd2_sel:  uop_opnd2_sel_i,
        br_op:      uop_br_op_i,
        wb_sel:     uop_wb_sel_i,
        csr_op:     uop_csr_op_i,
        pred_taken: uop_pred_taken_i
    };

    hs_slot #(.T(exec_pkg::uop_t)) u_in_slot (
        .clk_i     ( clk_i     ),
        .rstn_i    ( rstn_i    ),
        .up_req_i  ( uop_req_i ),
        .up_ack_o  ( uop_ack_o ),
        .up_data_i ( uop_in    ),
        .dn_req_o  ( mid_req   ),
        .dn_ack_i  ( mid_ack   ),
        .dn_data_o ( uop_q     )
    );

    exec_unit u_exec_unit (
        .uop_i    ( uop_q ),
        .result_o ( res_d )
    );

    hs_slot #(.T(exec_pkg::exec_result_t)) u_out_slot (
        .clk_i     ( clk_i     ),
        .rstn_i    ( rstn_i    ),
        .up_req_i  ( mid_req   ),
        .up_ack_o  ( mid_ack   ),
        .up_data_i ( res_d     ),
        .dn_req_o  ( res_req_o ),
        .dn_ack_i  ( res_ack_i ),
        .dn_data_o ( res_q     )
    );

    // unpack result record
    assign res_tag_o         = res_q.tag;
    assign res_rd_data_o     = res_q.rd_data;
    assign res_csr_wdata_o   = res_q.csr_wdata;
    assign res_br_update_o   = res_q.br_update;
    assign res_br_taken_o    = res_q.br_taken;
    assign res_mispredict_o  = res_q.mispredict;
    assign res_redirect_o    = res_q.redirect;
    assign res_redirect_pc_o = res_q.redirect_pc;
    assign res_trap_o        = res_q.trap;
    assign res_trap_code_o   = res_q.trap_code;

endmodule

//--- tests/exec_checker.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

// handshake properties of exec_top, attached with bind
module exec_checker (
    input logic                    clk_i,
    input logic                    rstn_i,
    input logic                    uop_req_i,
    input logic                    uop_ack_o,
    input logic                    res_req_o,
    input logic                    res_ack_i,
    input logic [`EXEC_TAG_W-1:0]  res_tag_o,
    input logic [`EXEC_XLEN-1:0]   res_rd_data_o,
    input logic [`EXEC_XLEN-1:0]   res_csr_wdata_o,
    input logic                    res_br_update_o,
    input logic                    res_br_taken_o,
    input logic                    res_mispredict_o,
    input logic                    res_redirect_o,
    input logic [`EXEC_XLEN-1:0]   res_redirect_pc_o,
    input logic                    res_trap_o,
    input logic [`EXEC_TRAP_W-1:0] res_trap_code_o
);

    logic [$bits(exec_pkg::exec_result_t)-1:0] res_bits;
    int unsigned assert_fails = 0;  // read by the testbench monitor

    assign res_bits = {res_tag_o, res_rd_data_o, res_csr_wdata_o, res_br_update_o,
                       res_br_taken_o, res_mispredict_o, res_redirect_o,
                       res_redirect_pc_o, res_trap_o, res_trap_code_o};

    // ----------------------------------------
    // result side
    // ----------------------------------------
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_req_o && !res_ack_i |=> res_req_o)
    else begin
        $error("res_req_o dropped before res_ack_i");
        assert_fails++;
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_req_o && !res_ack_i |=> $stable(res_bits))
    else begin
        $error("result fields changed while waiting for res_ack_i");
        assert_fails++;
    end

    // micro-op side, ack only answers a live request
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(uop_ack_o) |-> uop_req_i)
    else begin
        $error("uop_ack_o rose without uop_req_i");
        assert_fails++;
    end

    assert property (@(posedge clk_i) !rstn_i |=> (!uop_ack_o && !res_req_o))
    else begin
        $error("handshake outputs not low after reset");
        assert_fails++;
    end

endmodule

//--- tests/exec_tb.sv
`timescale 1ns/1ps

`include "exec_macros.svh"

module exec_tb;

    localparam int NUM_UOPS = 200;
    localparam int TIMEOUT  = NUM_UOPS * 16 + 100;

    logic                    clk_i = 1'b0;
    logic                    rstn_i;
    logic                    uop_req_i;
    logic                    uop_ack_o;
    logic [`EXEC_TAG_W-1:0]  uop_tag_i;
    logic [`EXEC_XLEN-1:0]   uop_pc_i;
    logic [`EXEC_XLEN-1:0]   uop_rs1_i;
    logic [`EXEC_XLEN-1:0]   uop_rs2_i;
    logic [`EXEC_XLEN-1:0]   uop_imm_i;
    logic [`EXEC_XLEN-1:0]   uop_csr_i;
    exec_pkg::alu_op_e       uop_alu_op_i;
    exec_pkg::opnd_sel_e     uop_opnd1_sel_i;
    exec_pkg::opnd_sel_e     uop_opnd2_sel_i;
    exec_pkg::br_op_e        uop_br_op_i;
    exec_pkg::wb_sel_e       uop_wb_sel_i;
    exec_pkg::csr_op_e       uop_csr_op_i;
    logic                    uop_pred_taken_i;
    logic                    res_req_o;
    logic                    res_ack_i;
    logic [`EXEC_TAG_W-1:0]  res_tag_o;
    logic [`EXEC_XLEN-1:0]   res_rd_data_o;
    logic [`EXEC_XLEN-1:0]   res_csr_wdata_o;
    logic                    res_br_update_o;
    logic                    res_br_taken_o;
    logic                    res_mispredict_o;
    logic                    res_redirect_o;
    logic [`EXEC_XLEN-1:0]   res_redirect_pc_o;
    logic                    res_trap_o;
    logic [`EXEC_TRAP_W-1:0] res_trap_code_o;

    exec_pkg::uop_t exp_q[$];  // sent and not yet answered
    int unsigned    n_done    = 0;
    int unsigned    cycle_cnt = 0;
    int unsigned    seed_val;
    logic           req_seen  = 1'b0;

    exec_top i_exec_top (.*);

    bind exec_top exec_checker i_checker (
        .clk_i(clk_i), .rstn_i(rstn_i), .uop_req_i(uop_req_i), .uop_ack_o(uop_ack_o),
        .res_req_o(res_req_o), .res_ack_i(res_ack_i), .res_tag_o(res_tag_o),
        .res_rd_data_o(res_rd_data_o), .res_csr_wdata_o(res_csr_wdata_o),
        .res_br_update_o(res_br_update_o), .res_br_taken_o(res_br_taken_o),
        .res_mispredict_o(res_mispredict_o), .res_redirect_o(res_redirect_o),
        .res_redirect_pc_o(res_redirect_pc_o), .res_trap_o(res_trap_o),
        .res_trap_code_o(res_trap_code_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h expected 0x%08h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic logic [31:0] pick_opnd(input exec_pkg::opnd_sel_e sel,
                                              input exec_pkg::uop_t u);
        case (sel)
            exec_pkg::OPND_RS1: return u.rs1;
            exec_pkg::OPND_RS2: return u.rs2;
            exec_pkg::OPND_IMM: return u.imm;
            exec_pkg::OPND_CSR: return u.csr;
            exec_pkg::OPND_PC:  return u.pc;
            default:            return 32'd0;
        endcase
    endfunction

    function automatic exec_pkg::exec_result_t ref_exec(input exec_pkg::uop_t u);
        exec_pkg::exec_result_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] alu;
        logic [31:0] tgt;
        logic [31:0] sra_fill;
        logic        slt;
        logic        cond;
        logic        taken;
        r     = '0;
        r.tag = u.tag;
        cond  = u.br_op inside {exec_pkg::BR_BEQ, exec_pkg::BR_BNE,
                                exec_pkg::BR_BLT, exec_pkg::BR_BGE};
        a = cond ? u.rs1 : pick_opnd(u.opnd1_sel, u);
        b = cond ? u.rs2 : pick_opnd(u.opnd2_sel, u);
        // signed less-than from sign bits and magnitude
        slt      = (a[31] != b[31]) ? a[31] : (a < b);
        sra_fill = {32{a[31]}} & ~(32'hffff_ffff >> b[4:0]);
        case (u.alu_op)
            exec_pkg::ALU_ADD:  alu = a + b;
            exec_pkg::ALU_SUB:  alu = a - b;
            exec_pkg::ALU_AND:  alu = a & b;
            exec_pkg::ALU_OR:   alu = a | b;
            exec_pkg::ALU_XOR:  alu = a ^ b;
            exec_pkg::ALU_SLL:  alu = a << b[4:0];
            exec_pkg::ALU_SRL:  alu = a >> b[4:0];
            exec_pkg::ALU_SRA:  alu = (a >> b[4:0]) | sra_fill;
            exec_pkg::ALU_SLT:  alu = {31'd0, slt};
            exec_pkg::ALU_SLTU: alu = (a < b) ? 32'd1 : 32'd0;
            default:            alu = 32'd0;
        endcase
        case (u.wb_sel)
            exec_pkg::WB_ALU:   r.rd_data = alu;
            exec_pkg::WB_OPND1: r.rd_data = a;
            exec_pkg::WB_LINK:  r.rd_data = u.pc + `EXEC_PC_STEP;
            default:            r.rd_data = u.csr;
        endcase
        if (u.csr_op == exec_pkg::CSR_RW) r.csr_wdata = u.rs1;
        if (u.csr_op == exec_pkg::CSR_RS) r.csr_wdata = alu;
        if (u.csr_op == exec_pkg::CSR_MRET) begin
            r.trap      = 1'b1;
            r.trap_code = `EXEC_TRAP_MRET;
        end
        case (u.br_op)
            exec_pkg::BR_BEQ: taken = (a == b);
            exec_pkg::BR_BNE: taken = (a != b);
            exec_pkg::BR_BLT: taken = slt;
            exec_pkg::BR_BGE: taken = !slt;
            default:          taken = 1'b1;  // jal, jalr
        endcase
        if (u.br_op == exec_pkg::BR_JALR) tgt = (u.rs1 + u.imm) & ~32'h1;
        else tgt = u.pc + u.imm;
        if (u.br_op != exec_pkg::BR_NONE) begin
            r.br_update   = 1'b1;
            r.br_taken    = taken;
            r.mispredict  = taken ^ u.pred_taken;
            r.redirect    = taken ^ u.pred_taken;
            r.redirect_pc = taken ? tgt : u.pc + `EXEC_PC_STEP;
        end
        return r;
    endfunction

    function automatic exec_pkg::uop_t rand_uop(input logic [31:0] idx);
        exec_pkg::uop_t u;
        logic [31:0]    r;
        u.tag = idx[`EXEC_TAG_W-1:0];
        u.pc  = $urandom() & 32'hffff_fffc;
        u.rs1 = $urandom();
        u.rs2 = ($urandom_range(0, 3) == 0) ? u.rs1 : $urandom();  // equal operands
        r     = $urandom();
        u.imm = {{20{r[11]}}, r[11:0]};
        u.csr = $urandom();
        u.alu_op    = exec_pkg::alu_op_e'(4'($urandom_range(0, 9)));
        u.opnd1_sel = exec_pkg::opnd_sel_e'(3'($urandom_range(0, 5)));
        u.opnd2_sel = exec_pkg::opnd_sel_e'(3'($urandom_range(0, 5)));
        if ($urandom_range(0, 1) == 0) u.br_op = exec_pkg::BR_NONE;
        else u.br_op = exec_pkg::br_op_e'(3'($urandom_range(1, 6)));
        u.wb_sel     = exec_pkg::wb_sel_e'(2'($urandom_range(0, 3)));
        u.csr_op     = exec_pkg::csr_op_e'(2'($urandom_range(0, 3)));
        u.pred_taken = 1'($urandom_range(0, 1));
        return u;
    endfunction

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin : producer
        exec_pkg::uop_t u;
        uop_req_i        = 1'b0;
        uop_tag_i        = '0;
        uop_pc_i         = '0;
        uop_rs1_i        = '0;
        uop_rs2_i        = '0;
        uop_imm_i        = '0;
        uop_csr_i        = '0;
        uop_alu_op_i     = exec_pkg::ALU_ADD;
        uop_opnd1_sel_i  = exec_pkg::OPND_ZERO;
        uop_opnd2_sel_i  = exec_pkg::OPND_ZERO;
        uop_br_op_i      = exec_pkg::BR_NONE;
        uop_wb_sel_i     = exec_pkg::WB_ALU;
        uop_csr_op_i     = exec_pkg::CSR_NONE;
        uop_pred_taken_i = 1'b0;
        @(posedge clk_i);
        while (!rstn_i) @(posedge clk_i);
        for (int i = 0; i < NUM_UOPS; i++) begin
            u = rand_uop(32'(i));
            @(posedge clk_i);
            uop_tag_i        <= u.tag;
            uop_pc_i         <= u.pc;
            uop_rs1_i        <= u.rs1;
            uop_rs2_i        <= u.rs2;
            uop_imm_i        <= u.imm;
            uop_csr_i        <= u.csr;
            uop_alu_op_i     <= u.alu_op;
            uop_opnd1_sel_i  <= u.opnd1_sel;
            uop_opnd2_sel_i  <= u.opnd2_sel;
            uop_br_op_i      <= u.br_op;
            uop_wb_sel_i     <= u.wb_sel;
            uop_csr_op_i     <= u.csr_op;
            uop_pred_taken_i <= u.pred_taken;
            uop_req_i        <= 1'b1;
            exp_q.push_back(u);
            @(posedge clk_i);
            while (!uop_ack_o) @(posedge clk_i);
            uop_req_i <= 1'b0;
            @(posedge clk_i);
            while (uop_ack_o) @(posedge clk_i);
        end
    end

    initial begin : consumer
        int unsigned delay;
        res_ack_i = 1'b0;
        @(posedge clk_i);
        while (!rstn_i) @(posedge clk_i);
        forever begin
            while (!res_req_o) @(posedge clk_i);
            delay = $urandom_range(0, 5);  // back-pressure
            repeat (delay) @(posedge clk_i);
            res_ack_i <= 1'b1;
            @(posedge clk_i);
            while (res_req_o) @(posedge clk_i);
            res_ack_i <= 1'b0;
            @(posedge clk_i);
        end
    end

    // ----------------------------------------
    // checking
    // ----------------------------------------
    always @(posedge clk_i) begin : compare
        exec_pkg::uop_t         u;
        exec_pkg::exec_result_t e;
        req_seen <= res_req_o;
        if (rstn_i && res_req_o && !req_seen) begin
            if (exp_q.size() == 0) abort_run("result arrived with no micro-op outstanding");
            u = exp_q.pop_front();
            e = ref_exec(u);
            check_val("res_tag_o", 32'(res_tag_o), 32'(e.tag));  // order check
            check_val("res_rd_data_o", res_rd_data_o, e.rd_data);
            check_val("res_csr_wdata_o", res_csr_wdata_o, e.csr_wdata);
            check_val("res_br_update_o", 32'(res_br_update_o), 32'(e.br_update));
            check_val("res_br_taken_o", 32'(res_br_taken_o), 32'(e.br_taken));
            check_val("res_mispredict_o", 32'(res_mispredict_o), 32'(e.mispredict));
            check_val("res_redirect_o", 32'(res_redirect_o), 32'(e.redirect));
            check_val("res_redirect_pc_o", res_redirect_pc_o, e.redirect_pc);
            check_val("res_trap_o", 32'(res_trap_o), 32'(e.trap));
            check_val("res_trap_code_o", 32'(res_trap_code_o), 32'(e.trap_code));
            n_done <= n_done + 1;
        end
    end

    always @(posedge clk_i) begin : watchdog
        cycle_cnt <= cycle_cnt + 1;
        if (i_exec_top.i_checker.assert_fails != 0) begin
            abort_run("a handshake assertion in exec_checker failed");
        end else if (cycle_cnt >= TIMEOUT) begin
            abort_run("run timed out before all results arrived");
        end
    end

    initial begin : main
        seed_val = $urandom(75);
        rstn_i   = 1'b0;
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        while (n_done < NUM_UOPS) @(posedge clk_i);
        repeat (20) @(posedge clk_i);  // catch stray extra results
        $display("** PASS **");
        $finish;
    end

endmodule

//--- build.f
+incdir+common
common/exec_pkg.sv
rtl/hs_slot.sv
execute/exec_alu.sv
execute/exec_unit.sv
rtl/exec_top.sv
tests/exec_checker.sv
tests/exec_tb.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module exec_tb -f build.f \
    --Mdir obj_dir -o exec_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# let assertion errors reach the testbench monitor instead of stopping at once
./obj_dir/exec_sim +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
